// ==== build.f ====
+incdir+rtl
rtl/glb_bank_pkg.sv
rtl/glb_cfg_pkg.sv
rtl/glb_rd_return.sv
rtl/glb_bank_sram.sv
rtl/glb_bank_ctrl.sv
rtl/glb_bank.sv
verification/glb_bank_tb.sv

// ==== Bender.yml ====
package:
  name: glb_bank

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/glb_bank_pkg.sv
      - rtl/glb_cfg_pkg.sv
      - rtl/glb_rd_return.sv
      - rtl/glb_bank_sram.sv
      - rtl/glb_bank_ctrl.sv
      - rtl/glb_bank.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/glb_bank_tb.sv

// ==== verification/glb_bank_tb.sv ====
// testbench for the global buffer bank with a reference memory model and response checks
`include "glb_defines.svh"

module glb_bank_tb;

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 10;
    localparam int LAT          = `GLB_MEM_RD_LATENCY;
    // words used by the test are all written before any read
    localparam int NW = 16;
    // counts of masked writes, configuration rounds, priority rounds and back-to-back reads
    localparam int NM = 12;
    localparam int NC = 8;
    localparam int NP = 6;
    localparam int NB = 16;
    localparam int TEST_CYCLES = RESET_CYCLES + 2 + 2 * NW + 2 * NM + 3 * NC + 4 * NP
                               + NB + 4 + LAT + 2;

    // one outstanding read as the model sees it
    typedef struct packed {
        logic        is_cfg;
        logic [3:0]  tag;
        logic [63:0] data;
        logic [31:0] cycle;
    } expect_t;

    logic clk;
    logic reset;

    glb_bank_pkg::packet_wr_t   packet_wr;
    glb_bank_pkg::packet_rdrq_t packet_rdrq;
    glb_bank_pkg::packet_rdrs_t packet_rdrs;
    glb_cfg_pkg::cfg_req_t      cfg_req;
    glb_cfg_pkg::cfg_rsp_t      cfg_rsp;

    integer      seed;
    int          checks;
    int          errors;
    logic [31:0] cycle_count;
    logic [63:0] ref_mem [512];
    expect_t     exp_q [$];
    logic [63:0] last_pkt_data;
    logic [63:0] last_cfg_data;

    glb_bank dut0 (
        .clk         (clk),
        .reset       (reset),
        .packet_wr   (packet_wr),
        .packet_rdrq (packet_rdrq),
        .packet_rdrs (packet_rdrs),
        .cfg_req     (cfg_req),
        .cfg_rsp     (cfg_rsp)
    );

    always #(PERIOD / 2) clk = ~clk;

    // cycle number read back by stimulus and checker
    always @(posedge clk) cycle_count <= cycle_count + 1;

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    function automatic logic [63:0] rand64();
        rand64 = {$random(seed), $random(seed)};
    endfunction

    function automatic int unsigned rand_idx();
        logic [31:0] r;
        r = $random(seed);
        rand_idx = r[3:0];
    endfunction

    // word index on top with half select in bit 2 and random low bits that the bank ignores
    function automatic logic [`GLB_BANK_ADDR_WIDTH-1:0] byte_addr(input int unsigned idx,
                                                                  input logic hi);
        logic [31:0] r;
        r = $random(seed);
        byte_addr = {idx[8:0], hi, r[1:0]};
    endfunction

    function automatic glb_bank_pkg::packet_wr_t pkt_wr_req(input int unsigned idx,
            input logic [63:0] data, input logic [63:0] mask);
        glb_bank_pkg::packet_wr_t w;
        logic [31:0] r;
        r = $random(seed);
        w.en      = 1'b1;
        w.addr    = byte_addr(idx, r[0]);
        w.data    = data;
        w.bit_sel = mask;
        return w;
    endfunction

    function automatic glb_bank_pkg::packet_rdrq_t pkt_rd_req(input int unsigned idx);
        glb_bank_pkg::packet_rdrq_t q;
        logic [31:0] r;
        r = $random(seed);
        q.en         = 1'b1;
        q.addr       = byte_addr(idx, r[4]);
        q.packet_sel = r[3:0];
        return q;
    endfunction

    function automatic glb_cfg_pkg::cfg_req_t cfg_wr_req(input int unsigned idx, input logic hi,
                                                          input logic [31:0] data);
        glb_cfg_pkg::cfg_req_t c;
        c         = '0;
        c.wr_en   = 1'b1;
        c.wr_addr = byte_addr(idx, hi);
        c.wr_data = data;
        return c;
    endfunction

    function automatic glb_cfg_pkg::cfg_req_t cfg_rd_req(input int unsigned idx, input logic hi);
        glb_cfg_pkg::cfg_req_t c;
        c         = '0;
        c.rd_en   = 1'b1;
        c.rd_addr = byte_addr(idx, hi);
        return c;
    endfunction

    // reference model where only the winner of the cycle touches the memory
    task automatic model_grant(input glb_cfg_pkg::cfg_req_t c,
                               input glb_bank_pkg::packet_wr_t w,
                               input glb_bank_pkg::packet_rdrq_t r);
        expect_t     e;
        int unsigned idx;
        e       = '0;
        e.cycle = cycle_count;
        if (c.wr_en) begin
            idx = c.wr_addr >> 3;
            if (c.wr_addr[2]) ref_mem[idx][63:32] = c.wr_data;
            else ref_mem[idx][31:0] = c.wr_data;
        end else if (c.rd_en) begin
            idx      = c.rd_addr >> 3;
            e.is_cfg = 1'b1;
            e.data   = c.rd_addr[2] ? {32'b0, ref_mem[idx][63:32]} : {32'b0, ref_mem[idx][31:0]};
            exp_q.push_back(e);
        end else if (w.en) begin
            idx = w.addr >> 3;
            // per-bit merge under the write mask
            for (int b = 0; b < 64; b++) begin
                if (w.bit_sel[b]) ref_mem[idx][b] = w.data[b];
            end
        end else if (r.en) begin
            idx    = r.addr >> 3;
            e.tag  = r.packet_sel;
            e.data = ref_mem[idx];
            exp_q.push_back(e);
        end
    endtask

    // one cycle of requests with inputs back to idle afterwards
    task automatic apply_cycle(input glb_cfg_pkg::cfg_req_t c,
                               input glb_bank_pkg::packet_wr_t w,
                               input glb_bank_pkg::packet_rdrq_t r);
        cfg_req     = c;
        packet_wr   = w;
        packet_rdrq = r;
        model_grant(c, w, r);
        @(posedge clk);
        #2;
        cfg_req     = '0;
        packet_wr   = '0;
        packet_rdrq = '0;
    endtask

    // response check in the middle of the cycle where registered outputs are stable
    always @(negedge clk) begin : response_check
        expect_t e;
        if (!reset) begin
            if (exp_q.size() > 0 && exp_q[0].cycle + LAT == cycle_count) begin
                e = exp_q.pop_front();
                if (e.is_cfg) begin
                    check_true(cfg_rsp.rd_data_valid, "configuration read got no response");
                    check_true(!packet_rdrs.valid, "packet valid during a configuration return");
                    check_value("cfg_rsp.rd_data", e.data, {32'b0, cfg_rsp.rd_data});
                    check_value("packet_rdrs.data", last_pkt_data, packet_rdrs.data);
                    last_cfg_data = e.data;
                end else begin
                    check_true(packet_rdrs.valid, "packet read got no response");
                    check_true(!cfg_rsp.rd_data_valid,
                               "configuration valid during a packet return");
                    check_value("packet_rdrs.data", e.data, packet_rdrs.data);
                    check_value("packet_rdrs.packet_sel", {60'b0, e.tag},
                                {60'b0, packet_rdrs.packet_sel});
                    check_value("cfg_rsp.rd_data", last_cfg_data, {32'b0, cfg_rsp.rd_data});
                    last_pkt_data = e.data;
                end
            end else begin
                check_true(!packet_rdrs.valid, "response valid with no outstanding read");
                check_true(!cfg_rsp.rd_data_valid, "response valid with no outstanding read");
                // held data while idle
                check_value("packet_rdrs.data", last_pkt_data, packet_rdrs.data);
                check_value("cfg_rsp.rd_data", last_cfg_data, {32'b0, cfg_rsp.rd_data});
            end
        end
    end

    reset_clears_outputs: assert property (@(posedge clk)
        reset |-> (!packet_rdrs.valid && !cfg_rsp.rd_data_valid
                   && packet_rdrs.data == '0 && cfg_rsp.rd_data == '0))
        else begin
            errors++;
            $display("%0t: response outputs not cleared during reset", $time);
        end

    one_return_per_cycle: assert property (@(posedge clk) disable iff (reset)
        !(packet_rdrs.valid && cfg_rsp.rd_data_valid))
        else begin
            errors++;
            $display("%0t: packet and configuration responses valid together", $time);
        end

    initial begin : watchdog
        #((TEST_CYCLES + 50) * PERIOD);
        $display("timeout, run did not finish within %0d clock periods", TEST_CYCLES + 50);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin : stimulus
        int unsigned a_idx;
        int unsigned b_idx;
        logic [63:0] d;
        clk           = 1'b0;
        reset         = 1'b1;
        seed          = 32'h563f;
        checks        = 0;
        errors        = 0;
        cycle_count   = '0;
        last_pkt_data = '0;
        last_cfg_data = '0;
        cfg_req       = '0;
        packet_wr     = '0;
        packet_rdrq   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        // two idle cycles after reset with held data at zero
        repeat (2) apply_cycle('0, '0, '0);

        // full-mask writes then tagged reads
        for (int i = 0; i < NW; i++) apply_cycle('0, pkt_wr_req(i, rand64(), '1), '0);
        for (int i = 0; i < NW; i++) apply_cycle('0, '0, pkt_rd_req(i));

        // masked writes each read back right after
        for (int k = 0; k < NM; k++) begin
            a_idx = rand_idx();
            apply_cycle('0, pkt_wr_req(a_idx, rand64(), rand64()), '0);
            apply_cycle('0, '0, pkt_rd_req(a_idx));
        end

        // configuration halves checked by packet and configuration reads
        for (int k = 0; k < NC; k++) begin
            a_idx = rand_idx();
            d     = rand64();
            apply_cycle(cfg_wr_req(a_idx, k[0], d[31:0]), '0, '0);
            apply_cycle('0, '0, pkt_rd_req(a_idx));
            apply_cycle(cfg_rd_req(a_idx, d[40]), '0, '0);
        end

        // same-cycle conflicts where the losers are dropped
        for (int k = 0; k < NP; k++) begin
            a_idx = rand_idx();
            b_idx = (a_idx + 1) % NW;
            d     = rand64();
            apply_cycle(cfg_wr_req(a_idx, d[0], d[63:32]), pkt_wr_req(b_idx, rand64(), '1), '0);
            apply_cycle(cfg_rd_req(a_idx, d[0]), pkt_wr_req(b_idx, rand64(), '1),
                        pkt_rd_req(b_idx));
            apply_cycle('0, pkt_wr_req(a_idx, rand64(), rand64()), pkt_rd_req(b_idx));
            apply_cycle('0, '0, pkt_rd_req(b_idx));
        end

        // back-to-back reads with every third one from the configuration side
        for (int k = 0; k < NB; k++) begin
            d = rand64();
            if (k % 3 == 2) apply_cycle(cfg_rd_req(rand_idx(), d[7]), '0, '0);
            else apply_cycle('0, '0, pkt_rd_req(rand_idx()));
        end
        repeat (4 + LAT + 2) apply_cycle('0, '0, '0);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== rtl/glb_bank.sv ====
// global buffer bank top, bank controller over one single-port memory
`include "glb_defines.svh"

module glb_bank (
    input  logic                       clk,
    input  logic                       reset,

    // packet side
    input  glb_bank_pkg::packet_wr_t   packet_wr,
    input  glb_bank_pkg::packet_rdrq_t packet_rdrq,
    output glb_bank_pkg::packet_rdrs_t packet_rdrs,

    // sram configuration side
    input  glb_cfg_pkg::cfg_req_t      cfg_req,
    output glb_cfg_pkg::cfg_rsp_t      cfg_rsp
);

    // controller to memory
    glb_bank_pkg::mem_req_t          mem_req;

    // memory read word back to the controller
    logic [`GLB_BANK_DATA_WIDTH-1:0] mem_data_out;

    // arbitration, half-word placement, read return
    glb_bank_ctrl bank_ctrl (
        .clk          (clk),
        .reset        (reset),
        .packet_wr    (packet_wr),
        .packet_rdrq  (packet_rdrq),
        .packet_rdrs  (packet_rdrs),
        .cfg_req      (cfg_req),
        .cfg_rsp      (cfg_rsp),
        .mem_req      (mem_req),
        .mem_data_out (mem_data_out)
    );

    // bank storage
    // two-cycle read data
    glb_bank_sram bank_sram (
        .clk          (clk),
        .mem_req      (mem_req),
        .mem_data_out (mem_data_out)
    );

endmodule

// ==== rtl/glb_bank_ctrl.sv ====
// bank controller, fixed-priority arbiter of configuration and packet accesses
`include "glb_defines.svh"

module glb_bank_ctrl (
    input  logic                            clk,
    input  logic                            reset,

    // packet side
    input  glb_bank_pkg::packet_wr_t        packet_wr,
    input  glb_bank_pkg::packet_rdrq_t      packet_rdrq,
    output glb_bank_pkg::packet_rdrs_t      packet_rdrs,

    // sram configuration side
    input  glb_cfg_pkg::cfg_req_t           cfg_req,
    output glb_cfg_pkg::cfg_rsp_t           cfg_rsp,

    // bank memory
    output glb_bank_pkg::mem_req_t          mem_req,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0] mem_data_out
);

    localparam int BANK_W = `GLB_BANK_DATA_WIDTH;
    localparam int CFG_W  = `GLB_CFG_DATA_WIDTH;
    // address bit that picks the high half of a word
    localparam int HALF_BIT = `GLB_BANK_BYTE_OFFSET - 1;

    logic cfg_wr_gnt;
    logic cfg_rd_gnt;
    logic pkt_wr_gnt;
    logic pkt_rd_gnt;

    logic                        cfg_wr_hi;
    glb_cfg_pkg::cfg_rd_meta_t   cfg_rd_meta;

    logic                        pkt_ret_valid;
    glb_bank_pkg::packet_sel_t   pkt_ret_meta;
    logic [BANK_W-1:0]           pkt_ret_data;

    logic                        cfg_ret_valid;
    glb_cfg_pkg::cfg_rd_meta_t   cfg_ret_meta;
    logic [BANK_W-1:0]           cfg_ret_data;

    // fixed priority
    // cfg write, cfg read, packet write, packet read
    // a loser is dropped, nothing is queued
    assign cfg_wr_gnt = cfg_req.wr_en;
    assign cfg_rd_gnt = !cfg_req.wr_en && cfg_req.rd_en;
    assign pkt_wr_gnt = !cfg_req.wr_en && !cfg_req.rd_en && packet_wr.en;
    assign pkt_rd_gnt = !cfg_req.wr_en && !cfg_req.rd_en && !packet_wr.en && packet_rdrq.en;

    assign cfg_wr_hi           = cfg_req.wr_addr[HALF_BIT];
    assign cfg_rd_meta.hi_half = cfg_req.rd_addr[HALF_BIT];

    // memory request mux
    always_comb begin
        mem_req = '0;
        if (cfg_wr_gnt) begin
            mem_req.wr_en = 1'b1;
            mem_req.addr  = cfg_req.wr_addr;
            // place the half-word and mask only that half
            if (cfg_wr_hi) begin
                mem_req.data    = {cfg_req.wr_data, {(BANK_W-CFG_W){1'b0}}};
                mem_req.bit_sel = {{CFG_W{1'b1}}, {(BANK_W-CFG_W){1'b0}}};
            end else begin
                mem_req.data    = {{(BANK_W-CFG_W){1'b0}}, cfg_req.wr_data};
                mem_req.bit_sel = {{(BANK_W-CFG_W){1'b0}}, {CFG_W{1'b1}}};
            end
        end else if (cfg_rd_gnt) begin
            mem_req.rd_en = 1'b1;
            mem_req.addr  = cfg_req.rd_addr;
        end else if (pkt_wr_gnt) begin
            mem_req.wr_en   = 1'b1;
            mem_req.addr    = packet_wr.addr;
            mem_req.data    = packet_wr.data;
            mem_req.bit_sel = packet_wr.bit_sel;
        end else if (pkt_rd_gnt) begin
            mem_req.rd_en = 1'b1;
            mem_req.addr  = packet_rdrq.addr;
        end
    end

    // packet read return, tag rides along
    glb_rd_return #(
        .meta_t (glb_bank_pkg::packet_sel_t)
    ) pkt_ret (
        .clk          (clk),
        .reset        (reset),
        .issue        (pkt_rd_gnt),
        .issue_meta   (packet_rdrq.packet_sel),
        .mem_data_out (mem_data_out),
        .ret_valid    (pkt_ret_valid),
        .ret_meta     (pkt_ret_meta),
        .ret_data     (pkt_ret_data)
    );

    // configuration read return, half select rides along
    glb_rd_return #(
        .meta_t (glb_cfg_pkg::cfg_rd_meta_t)
    ) cfg_ret (
        .clk          (clk),
        .reset        (reset),
        .issue        (cfg_rd_gnt),
        .issue_meta   (cfg_rd_meta),
        .mem_data_out (mem_data_out),
        .ret_valid    (cfg_ret_valid),
        .ret_meta     (cfg_ret_meta),
        .ret_data     (cfg_ret_data)
    );

    // packet response
    assign packet_rdrs.valid      = pkt_ret_valid;
    assign packet_rdrs.data       = pkt_ret_data;
    assign packet_rdrs.packet_sel = pkt_ret_meta;

    // config response
    // held word and held half select give the held half-word
    assign cfg_rsp.rd_data_valid = cfg_ret_valid;
    assign cfg_rsp.rd_data = cfg_ret_meta.hi_half ? cfg_ret_data[CFG_W +: CFG_W]
                                                  : cfg_ret_data[0 +: CFG_W];

endmodule

// ==== rtl/glb_bank_sram.sv ====
// behavioural single-port bank memory, bit-masked write and two-stage read
`include "glb_defines.svh"

module glb_bank_sram (
    input  logic                            clk,
    input  glb_bank_pkg::mem_req_t          mem_req,
    output logic [`GLB_BANK_DATA_WIDTH-1:0] mem_data_out
);

    localparam int BANK_W  = `GLB_BANK_DATA_WIDTH;
    localparam int IDX_W   = `GLB_BANK_ADDR_WIDTH - `GLB_BANK_BYTE_OFFSET;
    localparam int DEPTH   = 1 << IDX_W;

    logic [BANK_W-1:0] mem [DEPTH];

    logic [IDX_W-1:0]  req_idx;
    logic [IDX_W-1:0]  rd_idx_q;
    logic              rd_en_q;

    // word index, byte offset dropped
    assign req_idx = mem_req.addr[`GLB_BANK_ADDR_WIDTH-1:`GLB_BANK_BYTE_OFFSET];

    // masked write
    // bits with bit_sel low keep the stored value
    always_ff @(posedge clk) begin
        if (mem_req.wr_en) begin
            mem[req_idx] <= (mem[req_idx] & ~mem_req.bit_sel)
                          | (mem_req.data & mem_req.bit_sel);
        end
    end

    // first read stage, address capture
    always_ff @(posedge clk) begin
        rd_en_q <= mem_req.rd_en;
        if (mem_req.rd_en) begin
            rd_idx_q <= req_idx;
        end
    end

    // second read stage, array word to output register
    // holds while no read is in flight
    always_ff @(posedge clk) begin
        if (rd_en_q) begin
            mem_data_out <= mem[rd_idx_q];
        end
    end

endmodule

// ==== rtl/glb_rd_return.sv ====
// read-return aligner, delays read metadata by the memory latency and holds data
`include "glb_defines.svh"

module glb_rd_return #(
    parameter type meta_t = logic
) (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            issue,
    input  meta_t                           issue_meta,
    input  logic [`GLB_BANK_DATA_WIDTH-1:0] mem_data_out,
    output logic                            ret_valid,
    output meta_t                           ret_meta,
    output logic [`GLB_BANK_DATA_WIDTH-1:0] ret_data
);

    localparam int LAT = `GLB_MEM_RD_LATENCY;

    logic                            valid_pipe [LAT];
    meta_t                           meta_pipe  [LAT];
    meta_t                           meta_hold;
    logic [`GLB_BANK_DATA_WIDTH-1:0] data_hold;

    // valid shift, one stage per cycle of memory latency
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < LAT; i++) valid_pipe[i] <= 1'b0;
        end else begin
            valid_pipe[0] <= issue;
            for (int i = 1; i < LAT; i++) valid_pipe[i] <= valid_pipe[i-1];
        end
    end

    // metadata follows the valid, only looked at when valid
    always_ff @(posedge clk) begin
        meta_pipe[0] <= issue_meta;
        for (int i = 1; i < LAT; i++) meta_pipe[i] <= meta_pipe[i-1];
    end

    // keep last returned word and its metadata
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            data_hold <= '0;
            meta_hold <= '0;
        end else if (ret_valid) begin
            data_hold <= mem_data_out;
            meta_hold <= meta_pipe[LAT-1];
        end
    end

    assign ret_valid = valid_pipe[LAT-1];
    // live memory word on valid, held word otherwise
    assign ret_data  = ret_valid ? mem_data_out : data_hold;
    assign ret_meta  = ret_valid ? meta_pipe[LAT-1] : meta_hold;

endmodule

// ==== rtl/glb_cfg_pkg.sv ====
// configuration package with sram configuration request and response types
`include "glb_defines.svh"

package glb_cfg_pkg;

    // sram configuration request
    // address bit 2 picks the half of the memory word
    typedef struct packed {
        logic                            wr_en;
        logic                            rd_en;
        logic [`GLB_BANK_ADDR_WIDTH-1:0] wr_addr;
        logic [`GLB_BANK_ADDR_WIDTH-1:0] rd_addr;
        logic [`GLB_CFG_DATA_WIDTH-1:0]  wr_data;
    } cfg_req_t;

    // sram configuration response
    // rd_data holds its value while rd_data_valid is low
    typedef struct packed {
        logic [`GLB_CFG_DATA_WIDTH-1:0] rd_data;
        logic                           rd_data_valid;
    } cfg_rsp_t;

    // travels with a configuration read through the return pipe
    typedef struct packed {
        logic hi_half;
    } cfg_rd_meta_t;

endpackage

// ==== rtl/glb_bank_pkg.sv ====
// bank package with packet side and memory side request and response types
`include "glb_defines.svh"

package glb_bank_pkg;

    // requester tag carried from read request to read response
    typedef logic [`GLB_PACKET_SEL_WIDTH-1:0] packet_sel_t;

    // packet write, bit_sel set means the bit is written
    typedef struct packed {
        logic                            en;
        logic [`GLB_BANK_ADDR_WIDTH-1:0] addr;
        logic [`GLB_BANK_DATA_WIDTH-1:0] data;
        logic [`GLB_BANK_DATA_WIDTH-1:0] bit_sel;
    } packet_wr_t;

    // packet read request
    typedef struct packed {
        logic                            en;
        logic [`GLB_BANK_ADDR_WIDTH-1:0] addr;
        packet_sel_t                     packet_sel;
    } packet_rdrq_t;

    // packet read response, one-cycle valid pulse
    typedef struct packed {
        logic                            valid;
        logic [`GLB_BANK_DATA_WIDTH-1:0] data;
        packet_sel_t                     packet_sel;
    } packet_rdrs_t;

    // single request into the bank memory, byte address
    typedef struct packed {
        logic                            rd_en;
        logic                            wr_en;
        logic [`GLB_BANK_ADDR_WIDTH-1:0] addr;
        logic [`GLB_BANK_DATA_WIDTH-1:0] data;
        logic [`GLB_BANK_DATA_WIDTH-1:0] bit_sel;
    } mem_req_t;

endpackage

// ==== rtl/glb_defines.svh ====
// global buffer bank widths, configuration width and memory read latency
`ifndef GLB_DEFINES_SVH
`define GLB_DEFINES_SVH

// memory word width in bits
`define GLB_BANK_DATA_WIDTH 64

// byte address into the bank, 4 KB gives 512 words of 8 bytes
`define GLB_BANK_ADDR_WIDTH 12

// byte offset bits inside one memory word
`define GLB_BANK_BYTE_OFFSET 3

// sram configuration data, half a memory word
`define GLB_CFG_DATA_WIDTH 32

// packet select tag returned with read data
`define GLB_PACKET_SEL_WIDTH 4

// read enable to valid memory data, in cycles
`define GLB_MEM_RD_LATENCY 2

`endif
